// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    localparam word_t reset_pc = 32'd2048;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    // The same 32-bit word seen through each encoding format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic {op_a_reg, op_a_pc} op_a_sel_t;
    typedef enum logic {op_b_reg, op_b_imm} op_b_sel_t;
    typedef enum logic [1:0] {wb_alu, wb_imm, wb_link, wb_mem} wb_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        op_a_sel_t  op_a_sel;
        op_b_sel_t  op_b_sel;
        wb_sel_t    wb_sel;
        logic       reg_write;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_jump;
        logic [2:0] funct3;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      imm;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/rv_bus_master.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_bus_master (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::bus_req_t bus_req,
    output rv_pkg::bus_rsp_t bus_rsp,
    output rv_pkg::apb_req_t apb,
    input  rv_pkg::apb_rsp_t apb_rsp
);
    import rv_pkg::*;

    typedef enum logic [1:0] {st_idle, st_setup, st_access} bm_state_t;

    bm_state_t state;
    logic      write_q;
    word_t     addr_q;
    word_t     wdata_q;
    word_t     rdata_q;
    logic      done_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (bus_req.valid) begin
                        state <= st_setup;
                    end
                end
                st_setup: state <= st_access;
                st_access: begin
                    if (apb_rsp.pready) begin
                        state  <= st_idle;
                        done_q <= 1'b1; // Pulses in the idle cycle that follows.
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && bus_req.valid) begin
            write_q <= bus_req.write;
            addr_q  <= bus_req.addr;
            wdata_q <= bus_req.wdata;
        end
        if (state == st_access && apb_rsp.pready) begin
            rdata_q <= apb_rsp.prdata;
        end
    end

    assign apb.psel    = (state != st_idle);
    assign apb.penable = (state == st_access);
    assign apb.pwrite  = write_q;
    assign apb.paddr   = addr_q;
    assign apb.pwdata  = wdata_q;

    assign bus_rsp.done  = done_q;
    assign bus_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== logic/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decoder (
    input  rv_pkg::instr_u instr,
    output rv_pkg::ctrl_t  ctrl
);
    import rv_pkg::*;

    function automatic alu_op_t alu_from_funct(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
    assign imm_b = {{20{instr.b_fmt.imm_12}}, instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                    instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                    instr.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.funct3 = instr.r_fmt.funct3; // Register fields sit at the same bits in every format.
        ctrl.rs1    = instr.r_fmt.rs1;
        ctrl.rs2    = instr.r_fmt.rs2;
        ctrl.rd     = instr.r_fmt.rd;
        case (instr.r_fmt.opcode)
            opc_op: begin
                ctrl.alu_op    = alu_from_funct(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
                ctrl.reg_write = 1'b1;
            end
            opc_op_imm: begin
                // Only SRAI uses the upper immediate bit as an operation select.
                ctrl.alu_op    = alu_from_funct(instr.i_fmt.funct3,
                                   (instr.i_fmt.funct3 == 3'b101) && instr.r_fmt.funct7[5]);
                ctrl.op_b_sel  = op_b_imm;
                ctrl.imm       = imm_i;
                ctrl.reg_write = 1'b1;
            end
            opc_load: begin
                ctrl.op_b_sel  = op_b_imm;
                ctrl.imm       = imm_i;
                ctrl.wb_sel    = wb_mem;
                ctrl.is_load   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            opc_store: begin
                ctrl.op_b_sel = op_b_imm;
                ctrl.imm      = imm_s;
                ctrl.is_store = 1'b1;
            end
            opc_branch: begin
                case (instr.b_fmt.funct3[2:1])
                    2'b10:   ctrl.alu_op = alu_slt;
                    2'b11:   ctrl.alu_op = alu_sltu;
                    default: ctrl.alu_op = alu_sub;
                endcase
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
            end
            opc_lui: begin
                ctrl.imm       = imm_u;
                ctrl.wb_sel    = wb_imm;
                ctrl.reg_write = 1'b1;
            end
            opc_auipc: begin
                ctrl.op_a_sel  = op_a_pc;
                ctrl.op_b_sel  = op_b_imm;
                ctrl.imm       = imm_u;
                ctrl.reg_write = 1'b1;
            end
            opc_jal: begin
                ctrl.op_a_sel  = op_a_pc;
                ctrl.op_b_sel  = op_b_imm;
                ctrl.imm       = imm_j;
                ctrl.wb_sel    = wb_link;
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            opc_jalr: begin
                ctrl.op_b_sel  = op_b_imm;
                ctrl.imm       = imm_i;
                ctrl.wb_sel    = wb_link;
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl.reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
    input  logic             clk,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::reg_idx_t raddr_a,
    input  rv_pkg::reg_idx_t raddr_b,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata_a,
    output rv_pkg::word_t    rdata_b
);
    import rv_pkg::*;

    word_t regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a]; // Entry 0 is never written.
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// ==== logic/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_t alu_op,
    input  logic [2:0]      funct3,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result,
    output logic            taken
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

    // BEQ/BNE test the difference for zero, the others test the compare bit.
    assign taken = (funct3[2] ? result[0] : (result == '0)) ^ funct3[0];

endmodule

`default_nettype wire

// ==== logic/rv_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_sequencer (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::ctrl_t    ctrl,
    output rv_pkg::instr_u   instr,
    input  rv_pkg::word_t    rdata_a,
    input  rv_pkg::word_t    rdata_b,
    input  rv_pkg::word_t    alu_result,
    input  logic             taken,
    output rv_pkg::word_t    alu_a,
    output rv_pkg::word_t    alu_b,
    output logic             rf_we,
    output rv_pkg::word_t    rf_wdata,
    output rv_pkg::bus_req_t bus_req,
    input  rv_pkg::bus_rsp_t bus_rsp
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        st_halt, st_fetch, st_decode, st_execute, st_memory, st_writeback
    } seq_state_t;

    seq_state_t state;
    word_t      pc;
    instr_u     ir;
    word_t      op_a_q;
    word_t      op_b_q;
    word_t      alu_res_q;
    logic       taken_q;
    word_t      mem_q;
    word_t      pc_plus4;
    logic       mem_access;
    logic       use_target;

    assign pc_plus4   = pc + 32'd4;
    assign mem_access = ctrl.is_load || ctrl.is_store;
    // JAL is the only jump whose first operand is the pc.
    assign use_target = (ctrl.is_branch && taken_q) ||
                        (ctrl.is_jump && ctrl.op_a_sel == op_a_pc);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_halt;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_halt: state <= st_fetch;
                st_fetch: begin
                    if (bus_rsp.done) begin
                        state <= st_decode;
                    end
                end
                st_decode:  state <= st_execute;
                st_execute: state <= st_memory;
                st_memory: begin
                    if (!mem_access || bus_rsp.done) begin
                        state <= st_writeback;
                    end
                end
                st_writeback: begin
                    state <= st_fetch;
                    if (use_target) begin
                        pc <= pc + ctrl.imm;
                    end else if (ctrl.is_jump) begin
                        pc <= {alu_res_q[xlen-1:1], 1'b0};
                    end else begin
                        pc <= pc_plus4;
                    end
                end
                default: state <= st_halt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && bus_rsp.done) begin
            ir <= bus_rsp.rdata;
        end
        if (state == st_decode) begin
            op_a_q <= (ctrl.op_a_sel == op_a_pc) ? pc : rdata_a;
            op_b_q <= (ctrl.op_b_sel == op_b_imm) ? ctrl.imm : rdata_b;
        end
        if (state == st_execute) begin
            alu_res_q <= alu_result;
            taken_q   <= taken;
        end
        if (state == st_memory && bus_rsp.done) begin
            mem_q <= bus_rsp.rdata;
        end
    end

    always_comb begin
        bus_req.write = 1'b0;
        bus_req.addr  = pc;
        bus_req.wdata = rdata_b;
        if (state == st_memory) begin
            bus_req.write = ctrl.is_store;
            bus_req.addr  = alu_res_q;
        end
        // Dropped in the done cycle so one request makes one transfer.
        bus_req.valid = (state == st_fetch || (state == st_memory && mem_access)) &&
                        !bus_rsp.done;
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_imm:  rf_wdata = ctrl.imm;
            wb_link: rf_wdata = pc_plus4;
            wb_mem:  rf_wdata = mem_q;
            default: rf_wdata = alu_res_q;
        endcase
    end

    assign rf_we = (state == st_writeback) && ctrl.reg_write;
    assign instr = ir;
    assign alu_a = op_a_q;
    assign alu_b = op_b_q;

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::apb_req_t apb,
    input  rv_pkg::apb_rsp_t apb_rsp
);
    import rv_pkg::*;

    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    instr_u   instr;
    ctrl_t    ctrl;
    word_t    rdata_a;
    word_t    rdata_b;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    logic     taken;
    logic     rf_we;
    word_t    rf_wdata;

    rv_bus_master u_bus_master (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .apb     (apb),
        .apb_rsp (apb_rsp)
    );

    rv_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .we      (rf_we),
        .waddr   (ctrl.rd),
        .raddr_a (ctrl.rs1),
        .raddr_b (ctrl.rs2),
        .wdata   (rf_wdata),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    rv_alu u_alu (
        .alu_op (ctrl.alu_op),
        .funct3 (ctrl.funct3),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .taken  (taken)
    );

    rv_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .instr      (instr),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .alu_result (alu_result),
        .taken      (taken),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .rf_we      (rf_we),
        .rf_wdata   (rf_wdata),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp)
    );

endmodule

`default_nettype wire

// ==== testbench/rv_core_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva (
    input logic             clk,
    input logic             rst,
    input rv_pkg::apb_req_t apb,
    input rv_pkg::apb_rsp_t apb_rsp
);
    import rv_pkg::*;

    logic setup_seen;

    always_ff @(posedge clk) begin
        if (rst) begin
            setup_seen <= 1'b0;
        end else if (apb.psel) begin
            setup_seen <= 1'b1;
        end
    end

    setup_then_access: assert property (@(posedge clk) disable iff (rst)
        apb.psel && !apb.penable |=> apb.psel && apb.penable)
        else $error("APB setup phase was not followed by an access phase.");

    stable_in_access: assert property (@(posedge clk) disable iff (rst)
        apb.psel && apb.penable && !apb_rsp.pready |=>
            $stable(apb.paddr) && $stable(apb.pwrite) && $stable(apb.pwdata))
        else $error("APB address or data changed during a stalled access phase.");

    idle_in_reset: assert property (@(posedge clk) rst |=> !apb.psel)
        else $error("psel was high while reset was held.");

    first_fetch_addr: assert property (@(posedge clk) disable iff (rst)
        apb.psel && !apb.penable && !setup_seen |-> apb.paddr == reset_pc)
        else $error("First transfer after reset did not use the reset address.");

endmodule

bind rv_core rv_core_sva u_sva (
    .clk     (clk),
    .rst     (rst),
    .apb     (apb),
    .apb_rsp (apb_rsp)
);

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb;
    apb_rsp_t apb_rsp = '0;

    integer     seed = 60;
    logic       stall_on;
    logic [1:0] stall;
    word_t      mem [1024]; // Covers addresses 0 to 4095.
    word_t      pc_w;
    word_t      slot;

    word_t log_addr [$];
    word_t log_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];

    logic [3:0] r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    logic [3:0] i_ops [3]  = '{4'h0, 4'h2, 4'h4};
    logic [2:0] br_f3 [6]  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

    rv_core UUT (
        .clk     (clk),
        .rst     (rst),
        .apb     (apb),
        .apb_rsp (apb_rsp)
    );

    always #20 clk = ~clk;

    // Op code is {funct7[5], funct3} as in the OP encoding.
    function automatic word_t ref_alu(logic [3:0] op, word_t a, word_t b);
        case (op)
            4'h0:    return a + b;
            4'h8:    return a - b;
            4'h1:    return a << b[4:0];
            4'h2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'h3:    return (a < b) ? 32'd1 : 32'd0;
            4'h4:    return a ^ b;
            4'h5:    return a >> b[4:0];
            4'hd:    return word_t'($signed(a) >>> b[4:0]);
            4'h6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(string name, word_t expected, word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic emit(word_t instr);
        mem[pc_w[11:2]] = instr;
        pc_w = pc_w + 32'd4;
    endtask

    task automatic load_word(reg_idx_t rd, logic [11:0] addr);
        emit(i_type(addr, 5'd0, 3'b010, rd, opc_load));
    endtask

    task automatic store_word(reg_idx_t rs2, logic [11:0] addr);
        emit({addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], opc_store});
    endtask

    task automatic expect_store(string name, word_t addr, word_t data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic store_result(string name, reg_idx_t rs2, word_t value);
        store_word(rs2, slot[11:0]);
        expect_store(name, slot, value);
        slot = slot + 32'd4;
    endtask

    task automatic begin_test();
        int cycles;
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
        end
        cycles = 0;
        while (apb.psel) begin
            @(negedge clk);
            cycles++;
            if (cycles > 10) begin
                $display("The APB bus stayed busy while reset was held.");
                stop_with_failure();
            end
        end
        for (int i = 0; i < 1024; i++) begin
            mem[i] = ~{20'd0, i[9:0], 2'b00}; // Unwritten words read as the inverted address.
        end
        log_addr.delete();
        log_data.delete();
        pc_w = reset_pc;
        slot = 32'h400;
    endtask

    task automatic run_program(string name);
        int cycles;
        emit(j_type(21'd0, 5'd0)); // Spin in place once the program is done.
        rst = 1'b0;
        cycles = 0;
        while (exp_addr.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > 3000) begin
                $display("No store arrived within %0d cycles in the %s test.", cycles, name);
                stop_with_failure();
            end
        end
        for (int i = 0; i < 40; i++) begin
            @(posedge clk); // Leaves room for a stray store to show up.
        end
    endtask

    task automatic reg_alu_ops();
        word_t a;
        word_t b;
        begin_test();
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        mem[64] = a;
        mem[65] = b;
        load_word(5'd1, 12'h100);
        load_word(5'd2, 12'h104);
        foreach (r_ops[k]) begin
            emit(r_type({1'b0, r_ops[k][3], 5'd0}, 5'd2, 5'd1, r_ops[k][2:0], 5'd3));
            store_result($sformatf("register op %h", r_ops[k]), 5'd3, ref_alu(r_ops[k], a, b));
        end
        run_program("register ALU");
    endtask

    task automatic imm_alu_ops();
        word_t       a;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [19:0] upper;
        begin_test();
        a = word_t'($random(seed));
        mem[64] = a;
        load_word(5'd1, 12'h100);
        foreach (i_ops[k]) begin
            imm = 12'($random(seed));
            emit(i_type(imm, 5'd1, i_ops[k][2:0], 5'd3, opc_op_imm));
            store_result($sformatf("immediate op %h", i_ops[k]), 5'd3,
                         ref_alu(i_ops[k], a, {{20{imm[11]}}, imm}));
        end
        sh = 5'($random(seed));
        emit(i_type({7'b0100000, sh}, 5'd1, 3'b101, 5'd3, opc_op_imm));
        store_result("srai", 5'd3, ref_alu(4'hd, a, {27'd0, sh}));
        upper = 20'($random(seed));
        emit({upper, 5'd3, opc_lui});
        store_result("lui", 5'd3, {upper, 12'd0});
        upper = 20'($random(seed));
        emit({upper, 5'd3, opc_auipc});
        store_result("auipc", 5'd3, {upper, 12'd0} + pc_w - 32'd4);
        run_program("immediate ALU");
    endtask

    task automatic branch_case(logic [2:0] f3);
        word_t a;
        word_t b;
        begin_test();
        a = word_t'($random(seed));
        b = 1'($random(seed)) ? a : word_t'($random(seed)); // Equal operands half the time.
        mem[64] = a;
        mem[65] = b;
        load_word(5'd1, 12'h100);
        load_word(5'd2, 12'h104);
        emit(i_type(12'h5a5, 5'd0, 3'b000, 5'd3, opc_op_imm));
        emit(b_type(13'd8, 5'd2, 5'd1, f3));
        if (!branch_ref(f3, a, b)) begin
            expect_store($sformatf("branch %b fall through", f3), 32'h400, 32'h5a5);
        end
        store_word(5'd3, 12'h400);
        store_word(5'd3, 12'h404);
        expect_store($sformatf("branch %b target", f3), 32'h404, 32'h5a5);
        run_program("branch");
    endtask

    task automatic jump_links();
        word_t jump_pc;
        begin_test();
        jump_pc = pc_w;
        emit(j_type(21'd12, 5'd5));
        store_word(5'd0, 12'h7f0); // Skipped by the jump.
        store_word(5'd0, 12'h7f4);
        store_result("jal link", 5'd5, jump_pc + 32'd4);
        emit(i_type(12'h7ff, 5'd0, 3'b000, 5'd6, opc_op_imm));
        jump_pc = pc_w;
        // The sum points one byte past the target and the JALR has to clear bit 0.
        emit(i_type(12'(jump_pc + 32'd13 - 32'd2047), 5'd6, 3'b000, 5'd7, opc_jalr));
        store_word(5'd0, 12'h7f8);
        store_word(5'd0, 12'h7fc);
        store_result("jalr link", 5'd7, jump_pc + 32'd4);
        run_program("jump");
    endtask

    task automatic zero_reg_writes();
        begin_test();
        mem[64] = word_t'($random(seed)) | 32'd1;
        emit(i_type(12'h123, 5'd0, 3'b000, 5'd0, opc_op_imm));
        store_result("x0 after addi", 5'd0, 32'd0);
        load_word(5'd0, 12'h100);
        store_result("x0 after lw", 5'd0, 32'd0);
        run_program("x0");
    endtask

    // The memory model draws a new stall count at each setup phase.
    always @(negedge clk) begin
        apb_rsp.pready = 1'b0;
        if (apb.psel && !apb.penable) begin
            stall = stall_on ? 2'($random(seed)) : 2'd0;
        end else if (apb.psel && apb.penable) begin
            if (stall != 2'd0) begin
                stall = stall - 2'd1;
            end else begin
                apb_rsp.pready = 1'b1; // The transfer completes on the next rising edge.
                if (apb.pwrite) begin
                    mem[apb.paddr[11:2]] = apb.pwdata;
                    log_addr.push_back(apb.paddr);
                    log_data.push_back(apb.pwdata);
                end else begin
                    apb_rsp.prdata = mem[apb.paddr[11:2]];
                end
            end
        end
    end

    initial begin : compare_stores
        word_t addr;
        word_t data;
        string name;
        forever begin
            @(posedge clk);
            while (log_addr.size() > 0) begin
                addr = log_addr.pop_front();
                data = log_data.pop_front();
                if (exp_addr.size() == 0) begin
                    $display("A store to address %h arrived that no test expected.", addr);
                    stop_with_failure();
                end else begin
                    name = exp_name.pop_front();
                    check_value({name, " address"}, exp_addr.pop_front(), addr);
                    check_value({name, " data"}, exp_data.pop_front(), data);
                end
            end
        end
    end

    initial begin
        rst      = 1'b1;
        stall_on = 1'b0;
        stall    = 2'd0;
        for (int pass = 0; pass < 2; pass++) begin
            stall_on = (pass == 1); // Second pass repeats everything with pready stalls.
            reg_alu_ops();
            imm_alu_ops();
            foreach (br_f3[k]) begin
                branch_case(br_f3[k]);
            end
            jump_links();
            zero_reg_writes();
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/rv_pkg.sv
logic/rv_bus_master.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_sequencer.sv
logic/rv_core.sv
testbench/rv_core_sva.sv
testbench/tb_rv_core.sv
